// ==== verilog.f ====
+incdir+dv
rtl/rv_pkg.sv
rtl/alu.sv
rtl/fetch_unit.sv
rtl/decoder.sv
rtl/reg_file.sv
rtl/execute_unit.sv
rtl/rv_core.sv
dv/core_tb.sv

// ==== dv/ref_model.svh ====
// model state, stepped once per retired instruction
word_t       m_regs [32] = '{default: '0};
word_t       m_pc = reset_pc;
word_t       m_dmem [word_t];              // keyed by word aligned address
logic [31:0] lfsr_state = 32'h969df897;

// contents of a data word nobody has written yet
function automatic word_t dmem_fill(input word_t addr);
    return addr ^ 32'h5a3c_96e1;
endfunction

// fibonacci lfsr, taps 32 22 2 1, one step per bit taken
function automatic word_t take_bits(input int n);
    word_t r;
    logic  fb;
    r = '0;
    for (int i = 0; i < n; i++) begin
        fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
        lfsr_state = {lfsr_state[30:0], fb};
        r = {r[30:0], fb};
    end
    return r;
endfunction

// integer ops shared by register and immediate forms
function automatic word_t ref_alu(input logic [2:0] f3, input logic sub, input logic sra,
                                  input word_t x, input word_t y);
    case (f3)
        3'b000:  return sub ? x - y : x + y;
        3'b001:  return x << y[4:0];
        3'b010:  return {31'b0, $signed(x) < $signed(y)};
        3'b011:  return {31'b0, x < y};
        3'b100:  return x ^ y;
        3'b101:  return sra ? word_t'($signed(x) >>> y[4:0]) : x >> y[4:0];
        3'b110:  return x | y;
        default: return x & y;
    endcase
endfunction

// executes one instruction on the model, returns the store it makes
function automatic void ref_step(input word_t inst, output logic st_we,
                                 output word_t st_addr, output word_t st_data);
    logic [2:0] f3;
    reg_idx_t   rd;
    word_t      a;
    word_t      b;
    word_t      imm_i;
    word_t      imm_s;
    word_t      imm_b;
    word_t      imm_j;
    word_t      next_pc;
    word_t      val;
    word_t      addr;
    logic       wr;
    logic       taken;
    f3      = inst[14:12];
    rd      = inst[11:7];
    a       = m_regs[inst[19:15]];
    b       = m_regs[inst[24:20]];
    imm_i   = {{20{inst[31]}}, inst[31:20]};
    imm_s   = {{20{inst[31]}}, inst[31:25], inst[11:7]};
    imm_b   = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
    imm_j   = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
    next_pc = m_pc + 32'd4;
    val     = '0;
    wr      = 1'b0;
    taken   = 1'b0;
    st_we   = 1'b0;
    st_addr = '0;
    st_data = '0;
    case (inst[6:0])
        op_reg: begin
            val = ref_alu(f3, inst[30], inst[30], a, b);
            wr  = 1'b1;
        end
        op_imm: begin
            val = ref_alu(f3, 1'b0, inst[30], a, imm_i);   // no subtract form
            wr  = 1'b1;
        end
        op_lui: begin
            val = {inst[31:12], 12'b0};
            wr  = 1'b1;
        end
        op_auipc: begin
            val = m_pc + {inst[31:12], 12'b0};
            wr  = 1'b1;
        end
        op_jal: begin
            val     = m_pc + 32'd4;
            wr      = 1'b1;
            next_pc = m_pc + imm_j;
        end
        op_jalr: begin
            val     = m_pc + 32'd4;
            wr      = 1'b1;
            next_pc = (a + imm_i) & ~32'h1;
        end
        op_branch: begin
            case (f3)
                3'b000:  taken = (a == b);
                3'b001:  taken = (a != b);
                3'b100:  taken = $signed(a) < $signed(b);
                3'b101:  taken = $signed(a) >= $signed(b);
                3'b110:  taken = a < b;
                3'b111:  taken = a >= b;
                default: taken = 1'b0;
            endcase
            if (taken) begin
                next_pc = m_pc + imm_b;
            end
        end
        op_load: begin
            if (f3 == f3_word) begin
                addr = (a + imm_i) & ~32'h3;
                val  = m_dmem.exists(addr) ? m_dmem[addr] : dmem_fill(addr);
                wr   = 1'b1;
            end
        end
        op_store: begin
            if (f3 == f3_word) begin
                st_we           = 1'b1;
                st_addr         = (a + imm_s) & ~32'h3;
                st_data         = b;
                m_dmem[st_addr] = b;
            end
        end
        default: ;   // unknown opcode retires as a no-op
    endcase
    if (wr && rd != '0) begin
        m_regs[rd] = val;
    end
    m_pc = next_pc;
endfunction

// random instruction of a kept kind, or one that must act as a no-op
function automatic word_t gen_inst();
    logic [3:0]  kind;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [2:0]  f3;
    logic [11:0] imm12;
    logic [4:0]  shamt;
    logic [7:0]  r8;
    logic        alt;
    logic        near;
    logic [6:0]  opc;
    word_t       r32;
    word_t       off;
    kind  = 4'(take_bits(4));
    rd    = 5'(take_bits(4));     // x0 to x15
    rs1   = 5'(take_bits(4));
    rs2   = 5'(take_bits(4));
    f3    = 3'(take_bits(3));
    imm12 = 12'(take_bits(12));
    shamt = 5'(take_bits(5));
    r8    = 8'(take_bits(8));
    alt   = 1'(take_bits(1));
    near  = 1'(take_bits(1));
    r32   = take_bits(32);
    off   = {{22{r8[7]}}, r8, 2'b00};  // word multiple, both directions
    // memory ops often hit a small window off x0 so loads see stores
    if (near && kind >= 4'd12) begin
        rs1   = '0;
        imm12 = {6'b0, shamt[3:0], 2'b00};
    end
    case (kind)
        4'd0, 4'd1, 4'd2: begin
            alt = alt & (f3 == 3'b000 || f3 == 3'b101);
            return {1'b0, alt, 5'b0, rs2, rs1, f3, rd, op_reg};
        end
        4'd3, 4'd4, 4'd5: begin
            if (f3 == 3'b001) begin
                imm12 = {7'b0, shamt};
            end else if (f3 == 3'b101) begin
                imm12 = {1'b0, alt, 5'b0, shamt};
            end
            return {imm12, rs1, f3, rd, op_imm};
        end
        4'd6:    return {r32[31:12], rd, op_lui};
        4'd7:    return {r32[31:12], rd, op_auipc};
        4'd8:    return {off[20], off[10:1], off[11], off[19:12], rd, op_jal};
        4'd9:    return {imm12, rs1, 3'b000, rd, op_jalr};
        4'd10, 4'd11: begin
            if (f3[2:1] == 2'b01) begin
                f3[2] = 1'b1;   // 010 and 011 are no branch
            end
            return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], op_branch};
        end
        4'd12:   return {imm12, rs1, f3_word, rd, op_load};
        4'd13, 4'd14: begin
            return {imm12[11:5], rs2, rs1, f3_word, imm12[4:0], op_store};
        end
        default: begin
            if (f3 == f3_word) begin
                f3 = 3'b110;
            end
            opc = r32[6:0];
            if (opc inside {op_reg, op_imm, op_load, op_store, op_branch, op_jal, op_jalr,
                            op_lui, op_auipc}) begin
                opc = 7'b0001111;
            end
            case (r8[1:0])
                2'd0:    return {imm12, rs1, f3, rd, op_load};
                2'd1:    return {imm12[11:5], rs2, rs1, f3, imm12[4:0], op_store};
                default: return {r32[31:7], opc};
            endcase
        end
    endcase
endfunction

// ==== dv/core_tb.sv ====
`timescale 1ns/10ps

module core_tb
    import rv_pkg::*;
();
    localparam int clk_period   = 10;
    localparam int reset_cycles = 16;
    localparam int n_instr      = 4000;
    localparam int watchdog_ns  = (2 * n_instr + reset_cycles) * clk_period;

    logic  clk = 1'b0;
    logic  reset;
    word_t imem_addr;
    word_t imem_rdata;
    word_t dmem_addr;
    word_t dmem_wdata;
    logic  dmem_we;
    word_t dmem_rdata;

    word_t imem [word_t];      // keyed by pc word index
    word_t dmem [word_t];      // keyed by word address
    logic  pend_we = 1'b0;     // store of this cycle that lands at the next edge
    word_t pend_addr;
    word_t pend_data;

    `include "ref_model.svh"

    rv_core dut_i (
        .clk        (clk),
        .reset      (reset),
        .imem_addr  (imem_addr),
        .imem_rdata (imem_rdata),
        .dmem_addr  (dmem_addr),
        .dmem_wdata (dmem_wdata),
        .dmem_we    (dmem_we),
        .dmem_rdata (dmem_rdata)
    );

    always #(clk_period / 2) clk = ~clk;

    // first fetch of a word decides its instruction
    function automatic word_t fetch_inst(input word_t addr);
        if (!imem.exists(addr >> 2)) begin
            imem[addr >> 2] = gen_inst();
        end
        return imem[addr >> 2];
    endfunction

    function automatic word_t dmem_read(input word_t addr);
        return dmem.exists(addr) ? dmem[addr] : dmem_fill(addr);
    endfunction

    // memory models for both ports
    always @(posedge clk) begin
        if (pend_we) begin
            dmem[pend_addr] = pend_data;
            pend_we = 1'b0;
        end
        #1;
        imem_rdata = $isunknown(imem_addr) ? '0 : fetch_inst(imem_addr);
        #1;   // data port answers once its address has settled
        dmem_rdata = $isunknown(dmem_addr) ? '0 : dmem_read(dmem_addr);
    end

    task automatic report_error(input string msg);
        $display("** Error at %0d ns: %s", $time, msg);
        $display("ERRORS FOUND");
        $fatal(1);
    endtask

    task automatic check_word(input word_t got, input word_t exp, input string what);
        if (got !== exp) begin
            report_error($sformatf("%s is %h, expected %h (model pc %h)", what, got, exp, m_pc));
        end
    endtask

    task automatic check_store(input logic got_we, input word_t got_addr, input word_t got_data,
                               input logic exp_we, input word_t exp_addr, input word_t exp_data);
        if (got_we !== exp_we) begin
            report_error($sformatf("dmem_we is %b, expected %b", got_we, exp_we));
        end else if (exp_we) begin
            check_word(got_addr, exp_addr, "dmem_addr");
            check_word(got_data, exp_data, "dmem_wdata");
        end
    endtask

    initial begin
        word_t inst;
        logic  exp_we;
        word_t exp_addr;
        word_t exp_data;
        reset      = 1'b1;
        imem_rdata = '0;
        dmem_rdata = '0;
        // no store may leave the core while reset is high
        repeat (reset_cycles - 1) begin
            @(negedge clk);
            check_store(dmem_we, dmem_addr, dmem_wdata, 1'b0, '0, '0);
        end
        @(posedge clk);
        #1;
        reset = 1'b0;
        for (int n = 0; n < n_instr; n++) begin
            @(negedge clk);   // mid cycle where all combinational paths have settled
            check_word(imem_addr, m_pc, "imem_addr");
            inst = fetch_inst(m_pc);
            ref_step(inst, exp_we, exp_addr, exp_data);
            check_store(dmem_we, dmem_addr, dmem_wdata, exp_we, exp_addr, exp_data);
            pend_we   = dmem_we;
            pend_addr = dmem_addr;
            pend_data = dmem_wdata;
        end
        $display("NO ERRORS");
        $finish;
    end

    initial begin
        #(watchdog_ns);
        $display("watchdog timeout: %0d instructions did not retire within %0d ns",
                 n_instr, watchdog_ns);
        $display("ERRORS FOUND");
        $fatal(1);
    end

endmodule

// ==== rtl/rv_core.sv ====
`timescale 1ns/10ps

module rv_core
    import rv_pkg::*;
(
    input  logic  clk,
    input  logic  reset,
    output word_t imem_addr,
    input  word_t imem_rdata,
    output word_t dmem_addr,
    output word_t dmem_wdata,
    output logic  dmem_we,
    input  word_t dmem_rdata
);
    word_t      pc;
    word_t      snpc;
    logic       jump_en;
    word_t      jump_target;

    reg_idx_t   rs1;
    reg_idx_t   rs2;
    reg_idx_t   rd;
    word_t      imm;
    logic [2:0] funct3;
    alu_op_t    alu_op;
    logic       src_a_pc;
    logic       src_a_zero;
    logic       src_b_imm;
    logic       is_branch;
    logic       is_jal;
    logic       is_jalr;
    logic       mem_read;
    logic       mem_write;
    wb_sel_t    wb_sel;
    logic       reg_write;

    word_t      rdata1;
    word_t      rdata2;
    word_t      wb_data;
    logic       wb_en;

    assign imem_addr = pc;

    fetch_unit fetch_i (
        .clk         (clk),
        .reset       (reset),
        .jump_en     (jump_en),
        .jump_target (jump_target),
        .pc          (pc),
        .snpc        (snpc)
    );

    decoder decode_i (
        .inst       (imem_rdata),
        .rs1        (rs1),
        .rs2        (rs2),
        .rd         (rd),
        .imm        (imm),
        .inst_type  (),            // format only steers the immediate inside
        .funct3     (funct3),
        .alu_op     (alu_op),
        .src_a_pc   (src_a_pc),
        .src_a_zero (src_a_zero),
        .src_b_imm  (src_b_imm),
        .is_branch  (is_branch),
        .is_jal     (is_jal),
        .is_jalr    (is_jalr),
        .mem_read   (mem_read),
        .mem_write  (mem_write),
        .wb_sel     (wb_sel),
        .reg_write  (reg_write)
    );

    reg_file regs_i (
        .clk    (clk),
        .reset  (reset),
        .we     (wb_en),
        .waddr  (rd),
        .wdata  (wb_data),
        .raddr1 (rs1),
        .raddr2 (rs2),
        .rdata1 (rdata1),
        .rdata2 (rdata2)
    );

    execute_unit exec_i (
        .reset       (reset),
        .pc          (pc),
        .snpc        (snpc),
        .rdata1      (rdata1),
        .rdata2      (rdata2),
        .imm         (imm),
        .funct3      (funct3),
        .alu_op      (alu_op),
        .src_a_pc    (src_a_pc),
        .src_a_zero  (src_a_zero),
        .src_b_imm   (src_b_imm),
        .is_branch   (is_branch),
        .is_jal      (is_jal),
        .is_jalr     (is_jalr),
        .mem_read    (mem_read),
        .mem_write   (mem_write),
        .wb_sel      (wb_sel),
        .reg_write   (reg_write),
        .dmem_rdata  (dmem_rdata),
        .dmem_addr   (dmem_addr),
        .dmem_wdata  (dmem_wdata),
        .dmem_we     (dmem_we),
        .jump_en     (jump_en),
        .jump_target (jump_target),
        .wb_data     (wb_data),
        .wb_en       (wb_en)
    );

endmodule

// ==== rtl/execute_unit.sv ====
`timescale 1ns/10ps

module execute_unit
    import rv_pkg::*;
(
    input  logic       reset,
    input  word_t      pc,
    input  word_t      snpc,
    input  word_t      rdata1,
    input  word_t      rdata2,
    input  word_t      imm,
    input  logic [2:0] funct3,
    input  alu_op_t    alu_op,
    input  logic       src_a_pc,
    input  logic       src_a_zero,
    input  logic       src_b_imm,
    input  logic       is_branch,
    input  logic       is_jal,
    input  logic       is_jalr,
    input  logic       mem_read,
    input  logic       mem_write,
    input  wb_sel_t    wb_sel,
    input  logic       reg_write,
    input  word_t      dmem_rdata,
    output word_t      dmem_addr,
    output word_t      dmem_wdata,
    output logic       dmem_we,
    output logic       jump_en,
    output word_t      jump_target,
    output word_t      wb_data,
    output logic       wb_en
);
    word_t alu_a;
    word_t alu_b;
    word_t alu_result;
    logic  taken;       // branch condition holds

    assign alu_a = src_a_zero ? '0 : (src_a_pc ? pc : rdata1);
    assign alu_b = src_b_imm ? imm : rdata2;

    alu alu_i (
        .a      (alu_a),
        .b      (alu_b),
        .op     (alu_op),
        .result (alu_result)
    );

    // compare on the register values, the alu is busy with the target
    always_comb begin
        case (funct3)
            f3_beq:  taken = (rdata1 == rdata2);
            f3_bne:  taken = (rdata1 != rdata2);
            f3_blt:  taken = ($signed(rdata1) < $signed(rdata2));
            f3_bge:  taken = ($signed(rdata1) >= $signed(rdata2));
            f3_bltu: taken = (rdata1 < rdata2);
            f3_bgeu: taken = (rdata1 >= rdata2);
            default: taken = 1'b0;  // 010 / 011 fall through
        endcase
    end

    assign jump_en     = is_jal | is_jalr | (is_branch & taken);
    assign jump_target = is_jalr ? {alu_result[xlen-1:1], 1'b0} : alu_result;

    // word aligned, quiet when there is no access
    assign dmem_addr  = (mem_read | mem_write) ? {alu_result[xlen-1:2], 2'b00} : '0;
    assign dmem_wdata = rdata2;
    assign dmem_we    = mem_write & ~reset;

    always_comb begin
        case (wb_sel)
            wb_load: wb_data = dmem_rdata;
            wb_link: wb_data = snpc;        // return address
            default: wb_data = alu_result;
        endcase
    end

    assign wb_en = reg_write;

endmodule

// ==== rtl/reg_file.sv ====
`timescale 1ns/10ps

module reg_file
    import rv_pkg::*;
(
    input  logic     clk,
    input  logic     reset,
    input  logic     we,
    input  reg_idx_t waddr,
    input  word_t    wdata,
    input  reg_idx_t raddr1,
    input  reg_idx_t raddr2,
    output word_t    rdata1,
    output word_t    rdata2
);
    word_t regs [1:31]; // x0 has no storage

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && waddr != '0) begin
            regs[waddr] <= wdata;
        end
    end

    // combinational reads
    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

// ==== rtl/decoder.sv ====
`timescale 1ns/10ps

module decoder
    import rv_pkg::*;
(
    input  word_t      inst,
    output reg_idx_t   rs1,
    output reg_idx_t   rs2,
    output reg_idx_t   rd,
    output word_t      imm,
    output inst_t      inst_type,
    output logic [2:0] funct3,
    output alu_op_t    alu_op,
    output logic       src_a_pc,
    output logic       src_a_zero,
    output logic       src_b_imm,
    output logic       is_branch,
    output logic       is_jal,
    output logic       is_jalr,
    output logic       mem_read,
    output logic       mem_write,
    output wb_sel_t    wb_sel,
    output logic       reg_write
);
    logic [6:0] opcode;
    logic       alt;    // inst[30], picks sub / sra

    // R and I arithmetic share one funct3 map
    function automatic alu_op_t arith_op(input logic [2:0] f3, input logic use_sub,
                                         input logic use_sra);
        case (f3)
            3'b000:  return use_sub ? alu_sub : alu_add;
            3'b001:  return alu_sll;
            3'b010:  return alu_slt;
            3'b011:  return alu_sltu;
            3'b100:  return alu_xor;
            3'b101:  return use_sra ? alu_sra : alu_srl;
            3'b110:  return alu_or;
            default: return alu_and;
        endcase
    endfunction

    assign opcode = inst[6:0];
    assign rd     = inst[11:7];
    assign funct3 = inst[14:12];
    assign rs1    = inst[19:15];
    assign rs2    = inst[24:20];
    assign alt    = inst[30];

    always_comb begin
        case (opcode)
            op_reg:                    inst_type = fmt_r;
            op_imm, op_load, op_jalr:  inst_type = fmt_i;
            op_store:                  inst_type = fmt_s;
            op_branch:                 inst_type = fmt_b;
            op_lui, op_auipc:          inst_type = fmt_u;
            op_jal:                    inst_type = fmt_j;
            default:                   inst_type = fmt_n;
        endcase
    end

    always_comb begin
        case (inst_type)
            fmt_i:   imm = {{20{inst[31]}}, inst[31:20]};
            fmt_s:   imm = {{20{inst[31]}}, inst[31:25], inst[11:7]};
            fmt_b:   imm = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
            fmt_u:   imm = {inst[31:12], 12'b0};
            fmt_j:   imm = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
            default: imm = '0;
        endcase
    end

    always_comb begin
        alu_op     = alu_add; // address and target sums by default
        src_a_pc   = 1'b0;
        src_a_zero = 1'b0;
        src_b_imm  = 1'b0;
        is_branch  = 1'b0;
        is_jal     = 1'b0;
        is_jalr    = 1'b0;
        mem_read   = 1'b0;
        mem_write  = 1'b0;
        wb_sel     = wb_alu;
        reg_write  = 1'b0;
        case (opcode)
            op_reg: begin
                alu_op    = arith_op(funct3, alt, alt);
                reg_write = 1'b1;
            end
            op_imm: begin
                alu_op    = arith_op(funct3, 1'b0, alt); // no subi
                src_b_imm = 1'b1;
                reg_write = 1'b1;
            end
            op_lui: begin
                src_a_zero = 1'b1;
                src_b_imm  = 1'b1;
                reg_write  = 1'b1;
            end
            op_auipc: begin
                src_a_pc  = 1'b1;
                src_b_imm = 1'b1;
                reg_write = 1'b1;
            end
            op_jal: begin
                src_a_pc  = 1'b1;
                src_b_imm = 1'b1;
                is_jal    = 1'b1;
                wb_sel    = wb_link;
                reg_write = 1'b1;
            end
            op_jalr: begin
                src_b_imm = 1'b1;
                is_jalr   = 1'b1;
                wb_sel    = wb_link;
                reg_write = 1'b1;
            end
            op_branch: begin
                src_a_pc  = 1'b1;     // alu forms pc + offset
                src_b_imm = 1'b1;
                is_branch = 1'b1;
            end
            op_load: begin
                src_b_imm = 1'b1;
                if (funct3 == f3_word) begin
                    mem_read  = 1'b1;
                    wb_sel    = wb_load;
                    reg_write = 1'b1;
                end
            end
            op_store: begin
                src_b_imm = 1'b1;
                mem_write = (funct3 == f3_word); // sb / sh become no-ops
            end
            default: ;
        endcase
    end

endmodule

// ==== rtl/fetch_unit.sv ====
`timescale 1ns/10ps

module fetch_unit
    import rv_pkg::*;
(
    input  logic  clk,
    input  logic  reset,
    input  logic  jump_en,
    input  word_t jump_target,
    output word_t pc,
    output word_t snpc
);
    word_t dnpc; // pc of the next instruction

    // sequential successor, also the link value
    assign snpc = pc + 32'd4;

    assign dnpc = jump_en ? jump_target : snpc;

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= reset_pc;
        end else begin
            pc <= dnpc;
        end
    end

endmodule

// ==== rtl/alu.sv ====
`timescale 1ns/10ps

module alu
    import rv_pkg::*;
(
    input  word_t   a,
    input  word_t   b,
    input  alu_op_t op,
    output word_t   result
);
    logic [4:0] shamt;
    logic       lt_signed;
    logic       lt_unsigned;

    assign shamt       = b[4:0];
    assign lt_signed   = $signed(a) < $signed(b);
    assign lt_unsigned = a < b;

    always_comb begin
        case (op)
            alu_add:  result = a + b;
            alu_sub:  result = a - b;
            alu_sll:  result = a << shamt;
            alu_slt:  result = {{(xlen-1){1'b0}}, lt_signed};
            alu_sltu: result = {{(xlen-1){1'b0}}, lt_unsigned};
            alu_xor:  result = a ^ b;
            alu_srl:  result = a >> shamt;
            alu_sra:  result = word_t'($signed(a) >>> shamt); // keeps sign bit
            alu_or:   result = a | b;
            alu_and:  result = a & b;
            default:  result = a + b;
        endcase
    end

endmodule

// ==== rtl/rv_pkg.sv ====
package rv_pkg;

    localparam int xlen = 32;

    typedef logic [xlen-1:0] word_t;
    typedef logic [4:0]      reg_idx_t;

    localparam word_t reset_pc = 32'h8000_0000;

    // major opcodes of the kept subset
    localparam logic [6:0] op_reg    = 7'b0110011;
    localparam logic [6:0] op_imm    = 7'b0010011;
    localparam logic [6:0] op_load   = 7'b0000011;
    localparam logic [6:0] op_store  = 7'b0100011;
    localparam logic [6:0] op_branch = 7'b1100011;
    localparam logic [6:0] op_jal    = 7'b1101111;
    localparam logic [6:0] op_jalr   = 7'b1100111;
    localparam logic [6:0] op_lui    = 7'b0110111;
    localparam logic [6:0] op_auipc  = 7'b0010111;

    // branch conditions
    localparam logic [2:0] f3_beq  = 3'b000;
    localparam logic [2:0] f3_bne  = 3'b001;
    localparam logic [2:0] f3_blt  = 3'b100;
    localparam logic [2:0] f3_bge  = 3'b101;
    localparam logic [2:0] f3_bltu = 3'b110;
    localparam logic [2:0] f3_bgeu = 3'b111;

    localparam logic [2:0] f3_word = 3'b010; // lw / sw

    typedef enum logic [2:0] {
        fmt_r,
        fmt_i,
        fmt_s,
        fmt_b,
        fmt_u,
        fmt_j,
        fmt_n  // no immediate
    } inst_t;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_sll,
        alu_slt,
        alu_sltu,
        alu_xor,
        alu_srl,
        alu_sra,
        alu_or,
        alu_and
    } alu_op_t;

    typedef enum logic [1:0] {
        wb_alu,
        wb_load,
        wb_link
    } wb_sel_t;

endpackage
